// File: Bender.yml
package:
  name: blimp_core

sources:
  - src/blimp_arch_pkg.sv
  - src/blimp_uarch_pkg.sv
  - src/issue_intf.sv
  - src/result_intf.sv
  - src/regfile.sv
  - src/issue_ctrl.sv
  - src/alu_unit.sv
  - src/mul_unit.sv
  - src/commit_unit.sv
  - src/blimp_core.sv
  - target: test
    files:
      - verif/blimp_core_tb.sv

// File: src/alu_unit.sv
// Blimp integer ALU
// Single-cycle execute unit with a registered result
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic     clk,
  input  logic     reset,
  issue_intf.exec  issue,
  result_intf.exec result
);
  import blimp_arch_pkg::*;

  word_t      alu_out;
  logic [4:0] shamt;

  assign shamt = issue.op2[4:0];

  always_comb begin
    case (issue.op)
      OP_ADD, OP_ADDI: alu_out = issue.op1 + issue.op2;
      OP_SUB:  alu_out = issue.op1 - issue.op2;
      OP_AND:  alu_out = issue.op1 & issue.op2;
      OP_OR:   alu_out = issue.op1 | issue.op2;
      OP_XOR:  alu_out = issue.op1 ^ issue.op2;
      OP_SLT:  alu_out = ($signed(issue.op1) < $signed(issue.op2)) ? 32'd1 : 32'd0;
      OP_SLTU: alu_out = (issue.op1 < issue.op2) ? 32'd1 : 32'd0;
      OP_SLL:  alu_out = issue.op1 << shamt;
      OP_SRL:  alu_out = issue.op1 >> shamt;
      OP_SRA:  alu_out = $signed(issue.op1) >>> shamt;
      default: alu_out = '0;  // MUL never lands here
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) result.val <= 1'b0;
    else       result.val <= issue.val;
  end

  always_ff @(posedge clk) begin
    result.seq  <= issue.seq;
    result.rd   <= issue.rd;
    result.data <= alu_out;
  end

endmodule

`default_nettype wire

// File: src/blimp_arch_pkg.sv
// Blimp architectural types
// Data word, register address and the operation set seen by software
`default_nettype none

package blimp_arch_pkg;

  //------------------------------------------------
  // Register file geometry
  //------------------------------------------------

  localparam int c_num_arch_regs = 32;

  typedef logic [31:0]                        word_t;
  typedef logic [$clog2(c_num_arch_regs)-1:0] reg_addr_t;

  //------------------------------------------------
  // Operations
  //------------------------------------------------

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLT  = 4'd5,   // Signed compare
    OP_SLTU = 4'd6,   // Unsigned compare
    OP_SLL  = 4'd7,
    OP_SRL  = 4'd8,
    OP_SRA  = 4'd9,
    OP_ADDI = 4'd10,  // Immediate arrives in op2
    OP_MUL  = 4'd11   // Only op that goes to the multiplier
  } op_t;

endpackage

`default_nettype wire

// File: src/blimp_core.sv
// Blimp core slice
// Issue, ALU, multiplier, register file and in-order commit
`timescale 1ns/1ps
`default_nettype none

module blimp_core #(
  parameter int p_rob_depth  = 8,
  parameter int p_mul_stages = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_val,
  input  blimp_arch_pkg::op_t       inst_op,
  input  blimp_arch_pkg::reg_addr_t inst_rd,
  input  blimp_arch_pkg::reg_addr_t inst_rs1,
  input  blimp_arch_pkg::reg_addr_t inst_rs2,
  input  blimp_arch_pkg::word_t     inst_imm,
  output logic                      busy,
  output logic                      commit_val,
  output blimp_uarch_pkg::seq_num_t commit_seq,
  output blimp_arch_pkg::reg_addr_t commit_rd,
  output blimp_arch_pkg::word_t     commit_data
);
  import blimp_arch_pkg::*;

  //------------------------------------------------
  // Interfaces and wires
  //------------------------------------------------

  issue_intf  alu_issue ();
  issue_intf  mul_issue ();
  result_intf alu_result ();
  result_intf mul_result ();

  reg_addr_t raddr0;
  reg_addr_t raddr1;
  word_t     rdata0;
  word_t     rdata1;

  //------------------------------------------------
  // Units
  //------------------------------------------------

  issue_ctrl #(
    .p_rob_depth (p_rob_depth)
  ) ctrl (
    .alu    (alu_issue),
    .mul    (mul_issue),
    .alu_wb (alu_result),
    .mul_wb (mul_result),
    .*
  );

  regfile rf (
    .wr0 (alu_result),
    .wr1 (mul_result),
    .*
  );

  alu_unit alu_xu (
    .issue  (alu_issue),
    .result (alu_result),
    .*
  );

  mul_unit #(
    .p_mul_stages (p_mul_stages)
  ) mul_xu (
    .issue  (mul_issue),
    .result (mul_result),
    .*
  );

  commit_unit #(
    .p_rob_depth (p_rob_depth)
  ) wcu (
    .alu_wb (alu_result),
    .mul_wb (mul_result),
    .*
  );

endmodule

`default_nettype wire

// File: src/blimp_uarch_pkg.sv
// Blimp microarchitectural types
// Sequence tags that follow an instruction from issue to commit
`default_nettype none

package blimp_uarch_pkg;

  //------------------------------------------------
  // Sequence tags
  //------------------------------------------------

  localparam int c_seq_num_bits = 8;

  // Wraps freely, low bits pick the reorder buffer slot
  typedef logic [c_seq_num_bits-1:0] seq_num_t;

  // Half of the tag space so old and new tags never alias
  localparam int c_max_rob_depth = 2 ** (c_seq_num_bits - 1);

endpackage

`default_nettype wire

// File: src/commit_unit.sv
// Blimp commit unit
// Reorder buffer that collects out-of-order completions and retires
// them in program order, one per cycle
`timescale 1ns/1ps
`default_nettype none

module commit_unit #(
  parameter int p_rob_depth = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  result_intf.sink                   alu_wb,
  result_intf.sink                   mul_wb,
  output logic                       commit_val,
  output blimp_uarch_pkg::seq_num_t  commit_seq,
  output blimp_arch_pkg::reg_addr_t  commit_rd,
  output blimp_arch_pkg::word_t      commit_data
);
  import blimp_arch_pkg::*;
  import blimp_uarch_pkg::*;

  localparam int c_idx_bits = $clog2(p_rob_depth);

  typedef logic [c_idx_bits-1:0] rob_idx_t;

  logic      rob_done [p_rob_depth];
  reg_addr_t rob_rd   [p_rob_depth];
  word_t     rob_data [p_rob_depth];

  seq_num_t  head_seq;
  rob_idx_t  head_idx;
  rob_idx_t  alu_idx;
  rob_idx_t  mul_idx;
  logic      head_alu;
  logic      head_mul;
  logic      head_ready;
  reg_addr_t head_rd;
  word_t     head_data;

  assign head_idx = head_seq[c_idx_bits-1:0];
  assign alu_idx  = alu_wb.seq[c_idx_bits-1:0];
  assign mul_idx  = mul_wb.seq[c_idx_bits-1:0];

  //------------------------------------------------
  // Head selection
  //------------------------------------------------

  // A result for the head retires at the edge it arrives
  assign head_alu   = alu_wb.val && (alu_wb.seq == head_seq);
  assign head_mul   = mul_wb.val && (mul_wb.seq == head_seq);
  assign head_ready = rob_done[head_idx] | head_alu | head_mul;

  always_comb begin
    if (head_alu) begin
      head_rd   = alu_wb.rd;
      head_data = alu_wb.data;
    end else if (head_mul) begin
      head_rd   = mul_wb.rd;
      head_data = mul_wb.data;
    end else begin
      head_rd   = rob_rd[head_idx];
      head_data = rob_data[head_idx];
    end
  end

  //------------------------------------------------
  // Completion flags and retirement
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < p_rob_depth; i++) begin
        rob_done[i] <= 1'b0;
      end
      head_seq   <= '0;
      commit_val <= 1'b0;
    end else begin
      commit_val <= head_ready;
      if (alu_wb.val) rob_done[alu_idx] <= 1'b1;
      if (mul_wb.val) rob_done[mul_idx] <= 1'b1;
      if (head_ready) begin
        rob_done[head_idx] <= 1'b0;  // Wins over a bypassed write
        head_seq           <= head_seq + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_wb.val) begin
      rob_rd[alu_idx]   <= alu_wb.rd;
      rob_data[alu_idx] <= alu_wb.data;
    end
    if (mul_wb.val) begin
      rob_rd[mul_idx]   <= mul_wb.rd;
      rob_data[mul_idx] <= mul_wb.data;
    end
    if (head_ready) begin
      commit_seq  <= head_seq;
      commit_rd   <= head_rd;
      commit_data <= head_data;
    end
  end

endmodule

`default_nettype wire

// File: src/issue_ctrl.sv
// Blimp issue controller
// Holds one decoded instruction, checks the scoreboard and reorder
// buffer room, then sends it to the ALU or the multiplier with a tag
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl #(
  parameter int p_rob_depth = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_val,
  input  blimp_arch_pkg::op_t       inst_op,
  input  blimp_arch_pkg::reg_addr_t inst_rd,
  input  blimp_arch_pkg::reg_addr_t inst_rs1,
  input  blimp_arch_pkg::reg_addr_t inst_rs2,
  input  blimp_arch_pkg::word_t     inst_imm,
  output logic                      busy,
  output blimp_arch_pkg::reg_addr_t raddr0,
  output blimp_arch_pkg::reg_addr_t raddr1,
  input  blimp_arch_pkg::word_t     rdata0,
  input  blimp_arch_pkg::word_t     rdata1,
  issue_intf.issue                  alu,
  issue_intf.issue                  mul,
  result_intf.sink                  alu_wb,
  result_intf.sink                  mul_wb,
  input  logic                      commit_val
);
  import blimp_arch_pkg::*;
  import blimp_uarch_pkg::*;

  localparam int c_cnt_bits = $clog2(c_max_rob_depth + 1);

  //------------------------------------------------
  // Input buffer
  //------------------------------------------------

  logic      buf_val;
  op_t       buf_op;
  reg_addr_t buf_rd;
  reg_addr_t buf_rs1;
  reg_addr_t buf_rs2;
  word_t     buf_imm;

  logic accept;
  logic can_issue;

  assign accept = inst_val & ~busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_val <= 1'b0;
    end else if (accept) begin
      buf_val <= 1'b1;
    end else if (can_issue) begin
      buf_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      buf_op  <= inst_op;
      buf_rd  <= inst_rd;
      buf_rs1 <= inst_rs1;
      buf_rs2 <= inst_rs2;
      buf_imm <= inst_imm;
    end
  end

  //------------------------------------------------
  // Scoreboard and in-flight count
  //------------------------------------------------

  logic [c_num_arch_regs-1:0] pending;
  logic [c_cnt_bits-1:0]      in_flight;
  logic                       uses_rs2;
  logic                       hazard;
  logic                       room;

  assign uses_rs2  = (buf_op != OP_ADDI);
  assign hazard    = pending[buf_rs1] | (uses_rs2 & pending[buf_rs2]) | pending[buf_rd];
  assign room      = (in_flight < c_cnt_bits'(p_rob_depth));
  assign can_issue = buf_val & ~hazard & room;
  assign busy      = buf_val & ~can_issue;  // Free again in the issue cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (alu_wb.val) pending[alu_wb.rd] <= 1'b0;
      if (mul_wb.val) pending[mul_wb.rd] <= 1'b0;
      // Issued rd is never pending, so no clash with the clears
      if (can_issue && (buf_rd != '0)) pending[buf_rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + c_cnt_bits'(can_issue) - c_cnt_bits'(commit_val);
    end
  end

  //------------------------------------------------
  // Dispatch
  //------------------------------------------------

  logic      alu_val_q;
  logic      mul_val_q;
  seq_num_t  next_seq;
  seq_num_t  iss_seq;
  reg_addr_t iss_rd;
  op_t       iss_op;
  word_t     iss_op1;
  word_t     iss_op2;

  assign raddr0 = buf_rs1;
  assign raddr1 = buf_rs2;

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_val_q <= 1'b0;
      mul_val_q <= 1'b0;
      next_seq  <= '0;
    end else begin
      alu_val_q <= can_issue & (buf_op != OP_MUL);
      mul_val_q <= can_issue & (buf_op == OP_MUL);
      if (can_issue) next_seq <= next_seq + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (can_issue) begin
      iss_seq <= next_seq;
      iss_rd  <= buf_rd;
      iss_op  <= buf_op;
      iss_op1 <= rdata0;
      iss_op2 <= (buf_op == OP_ADDI) ? buf_imm : rdata1;
    end
  end

  // Both units see the same payload, only the strobe is steered
  assign alu.val = alu_val_q;
  assign alu.seq = iss_seq;
  assign alu.rd  = iss_rd;
  assign alu.op  = iss_op;
  assign alu.op1 = iss_op1;
  assign alu.op2 = iss_op2;

  assign mul.val = mul_val_q;
  assign mul.seq = iss_seq;
  assign mul.rd  = iss_rd;
  assign mul.op  = iss_op;
  assign mul.op1 = iss_op1;
  assign mul.op2 = iss_op2;

endmodule

`default_nettype wire

// File: src/issue_intf.sv
// Issue path into an execute unit
// One instruction per strobe, the unit takes every strobe
`timescale 1ns/1ps
`default_nettype none

interface issue_intf;
  import blimp_arch_pkg::*;
  import blimp_uarch_pkg::*;

  logic      val;   // One-cycle strobe
  seq_num_t  seq;
  reg_addr_t rd;
  op_t       op;
  word_t     op1;
  word_t     op2;   // Holds the immediate for ADDI

  modport issue (
    output val, seq, rd, op, op1, op2
  );

  modport exec (
    input val, seq, rd, op, op1, op2
  );

endinterface

`default_nettype wire

// File: src/mul_unit.sv
// Blimp multiplier
// Low 32 bits of the product, p_mul_stages cycles from issue to result
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
  parameter int p_mul_stages = 4
) (
  input  logic     clk,
  input  logic     reset,
  issue_intf.exec  issue,
  result_intf.exec result
);
  import blimp_arch_pkg::*;
  import blimp_uarch_pkg::*;

  logic      stage_val  [p_mul_stages];
  seq_num_t  stage_seq  [p_mul_stages];
  reg_addr_t stage_rd   [p_mul_stages];
  word_t     stage_prod [p_mul_stages];

  //------------------------------------------------
  // Valid chain
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < p_mul_stages; i++) begin
        stage_val[i] <= 1'b0;
      end
    end else begin
      stage_val[0] <= issue.val;
      for (int i = 1; i < p_mul_stages; i++) begin
        stage_val[i] <= stage_val[i-1];
      end
    end
  end

  //------------------------------------------------
  // Payload chain
  //------------------------------------------------

  always_ff @(posedge clk) begin
    stage_seq[0]  <= issue.seq;
    stage_rd[0]   <= issue.rd;
    stage_prod[0] <= issue.op1 * issue.op2;  // Truncates to 32 bits
    // Later stages just carry the product so retiming can spread it
    for (int i = 1; i < p_mul_stages; i++) begin
      stage_seq[i]  <= stage_seq[i-1];
      stage_rd[i]   <= stage_rd[i-1];
      stage_prod[i] <= stage_prod[i-1];
    end
  end

  assign result.val  = stage_val[p_mul_stages-1];
  assign result.seq  = stage_seq[p_mul_stages-1];
  assign result.rd   = stage_rd[p_mul_stages-1];
  assign result.data = stage_prod[p_mul_stages-1];

endmodule

`default_nettype wire

// File: src/regfile.sv
// Blimp register file
// Two combinational reads, one write port per execute unit
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                      clk,
  input  logic                      reset,
  input  blimp_arch_pkg::reg_addr_t raddr0,
  input  blimp_arch_pkg::reg_addr_t raddr1,
  output blimp_arch_pkg::word_t     rdata0,
  output blimp_arch_pkg::word_t     rdata1,
  result_intf.sink                  wr0,
  result_intf.sink                  wr1
);
  import blimp_arch_pkg::*;

  word_t regs [1:c_num_arch_regs-1];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < c_num_arch_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Scoreboard keeps the two write addresses apart
      if (wr0.val && (wr0.rd != '0)) regs[wr0.rd] <= wr0.data;
      if (wr1.val && (wr1.rd != '0)) regs[wr1.rd] <= wr1.data;
    end
  end

  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire

// File: src/result_intf.sv
// Completion path out of an execute unit
// Seen by the register file, the reorder buffer and the scoreboard
`timescale 1ns/1ps
`default_nettype none

interface result_intf;
  import blimp_arch_pkg::*;
  import blimp_uarch_pkg::*;

  logic      val;   // One-cycle strobe
  seq_num_t  seq;
  reg_addr_t rd;
  word_t     data;

  modport exec (
    output val, seq, rd, data
  );

  modport sink (
    input val, seq, rd, data
  );

endinterface

`default_nettype wire

// File: verif/blimp_core_tb.sv
// Blimp core testbench
// Sends decoded instructions, runs them through an in-order model and
// checks every commit against it
`timescale 1ns/1ps
`default_nettype none

module blimp_core_tb;
  import blimp_arch_pkg::*;
  import blimp_uarch_pkg::*;

  localparam int c_mul_stages  = 4;     // DUT default
  localparam int c_seed        = 8797;
  localparam int c_num_fill    = 31;
  localparam int c_alu_rounds  = 6;
  localparam int c_num_alu_ops = 11;
  localparam int c_ooo_rounds  = 2;
  localparam int c_ooo_alu     = 6;
  localparam int c_num_chain   = 12;
  localparam int c_num_random  = 300;
  localparam int c_total_insts = c_num_fill + c_alu_rounds * c_num_alu_ops
                                 + c_ooo_rounds * (1 + c_ooo_alu) + c_num_chain
                                 + c_num_random;
  localparam int c_max_cycles  = c_total_insts * (c_mul_stages + 12) + 200;

  logic      clk;
  logic      reset;
  logic      inst_val;
  op_t       inst_op;
  reg_addr_t inst_rd;
  reg_addr_t inst_rs1;
  reg_addr_t inst_rs2;
  word_t     inst_imm;
  logic      busy;
  logic      commit_val;
  seq_num_t  commit_seq;
  reg_addr_t commit_rd;
  word_t     commit_data;

  word_t     model_regs [c_num_arch_regs];
  seq_num_t  model_seq;
  seq_num_t  exp_seq_q  [$];
  reg_addr_t exp_rd_q   [$];
  word_t     exp_data_q [$];
  int        errors;
  int        commits;
  int        cycle_cnt;

  op_t alu_ops [c_num_alu_ops] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                   OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_ADDI};

  blimp_core dut (.*);

  always #10 clk = ~clk;

  //--------------------------------------------------
  // Reference model and compare tasks
  //--------------------------------------------------

  function automatic word_t ref_result(op_t op, word_t a, word_t b);
    logic [63:0] full;
    full = {32'd0, a} * {32'd0, b};
    case (op)
      OP_ADD, OP_ADDI: return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
      OP_SLTU: return {31'd0, a < b};
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return $signed(a) >>> b[4:0];
      OP_MUL:  return full[31:0];   // Low half of the product
      default: return '0;
    endcase
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_reg(string name, reg_addr_t exp, reg_addr_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_seq(string name, seq_num_t exp, seq_num_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  //--------------------------------------------------
  // Driver
  //--------------------------------------------------

  // Applies the instruction to the model, then strobes it into the DUT
  task automatic send_inst(op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                           word_t imm);
    word_t a;
    word_t b;
    word_t res;
    a   = model_regs[rs1];
    b   = (op == OP_ADDI) ? imm : model_regs[rs2];
    res = ref_result(op, a, b);
    if (rd != '0) model_regs[rd] = res;
    exp_seq_q.push_back(model_seq);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
    model_seq++;
    while (busy !== 1'b0) @(negedge clk);
    inst_val = 1'b1;
    inst_op  = op;
    inst_rd  = rd;
    inst_rs1 = rs1;
    inst_rs2 = rs2;
    inst_imm = imm;
    @(negedge clk);
    inst_val = 1'b0;
  endtask

  function automatic reg_addr_t rand_reg(int lo, int hi);
    return reg_addr_t'($urandom_range(hi, lo));
  endfunction

  //--------------------------------------------------
  // Commit checker
  //--------------------------------------------------

  always @(negedge clk) begin
    if (!reset && commit_val === 1'b1) begin
      commits++;
      if (exp_seq_q.size() == 0) begin
        errors++;
        $display("Error: commit of seq %h arrived with nothing outstanding", commit_seq);
      end else begin
        check_seq("commit_seq", exp_seq_q.pop_front(), commit_seq);
        check_reg("commit_rd", exp_rd_q.pop_front(), commit_rd);
        check_word("commit_data", exp_data_q.pop_front(), commit_data);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= c_max_cycles) begin
      $display("Timeout after %0d cycles, %0d commits still missing",
               cycle_cnt, exp_seq_q.size());
      $display("Summary: %0d errors, %0d commits seen", errors, commits);
      $display("test failed");
      $finish;
    end
  end

  //--------------------------------------------------
  // Stimulus
  //--------------------------------------------------

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    inst_val  = 1'b0;
    inst_op   = OP_ADD;
    inst_rd   = '0;
    inst_rs1  = '0;
    inst_rs2  = '0;
    inst_imm  = '0;
    model_seq = '0;
    errors    = 0;
    commits   = 0;
    cycle_cnt = 0;
    for (int i = 0; i < c_num_arch_regs; i++) model_regs[i] = '0;
    void'($urandom(c_seed));

    // Outputs quiet through reset and just after
    repeat (16) begin
      @(negedge clk);
      check_bit("busy", 1'b0, busy);
      check_bit("commit_val", 1'b0, commit_val);
    end
    reset = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_bit("busy", 1'b0, busy);
      check_bit("commit_val", 1'b0, commit_val);
    end

    // Load x1..x31 with random values
    for (int r = 1; r <= c_num_fill; r++) begin
      send_inst(OP_ADDI, reg_addr_t'(r), '0, '0, $urandom());
    end

    // Every ALU op, ADDI with negative immediates
    for (int n = 0; n < c_alu_rounds; n++) begin
      for (int k = 0; k < c_num_alu_ops; k++) begin
        send_inst(alu_ops[k], rand_reg(1, 31), rand_reg(0, 31), rand_reg(0, 31),
                  32'hFFFF_F000 | $urandom_range(4095, 0));
      end
    end

    // Slow MUL overtaken by independent ALU work
    for (int n = 0; n < c_ooo_rounds; n++) begin
      send_inst(OP_MUL, 5'd20, rand_reg(1, 19), rand_reg(1, 19), '0);
      for (int k = 0; k < c_ooo_alu; k++) begin
        send_inst(alu_ops[$urandom_range(c_num_alu_ops - 1, 0)], reg_addr_t'(21 + k),
                  rand_reg(1, 19), rand_reg(1, 19), $urandom());
      end
    end

    // Dependency chain with WAW on x5 and reads of x0
    send_inst(OP_MUL,  5'd5,  5'd1,  5'd2,  '0);
    send_inst(OP_ADD,  5'd6,  5'd5,  5'd3,  '0);
    send_inst(OP_MUL,  5'd5,  5'd6,  5'd5,  '0);
    send_inst(OP_SUB,  5'd7,  5'd5,  5'd0,  '0);
    send_inst(OP_ADDI, 5'd5,  5'd5,  5'd0,  32'hFFFF_FFFD);
    send_inst(OP_MUL,  5'd8,  5'd5,  5'd5,  '0);
    send_inst(OP_XOR,  5'd9,  5'd8,  5'd6,  '0);
    send_inst(OP_ADD,  5'd0,  5'd9,  5'd8,  '0);
    send_inst(OP_OR,   5'd10, 5'd0,  5'd9,  '0);
    send_inst(OP_SLT,  5'd11, 5'd10, 5'd5,  '0);
    send_inst(OP_MUL,  5'd12, 5'd0,  5'd7,  '0);
    send_inst(OP_SRA,  5'd13, 5'd12, 5'd11, '0);

    // Long mixed stream, MUL about one in three
    for (int n = 0; n < c_num_random; n++) begin
      if ($urandom_range(2, 0) == 0) begin
        send_inst(OP_MUL, rand_reg(0, 31), rand_reg(0, 31), rand_reg(0, 31), '0);
      end else begin
        send_inst(alu_ops[$urandom_range(c_num_alu_ops - 1, 0)], rand_reg(0, 31),
                  rand_reg(0, 31), rand_reg(0, 31), $urandom());
      end
    end

    while (exp_seq_q.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);   // Catch any stray commits

    $display("Summary: %0d errors, %0d commits seen", errors, commits);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
src/blimp_arch_pkg.sv
src/blimp_uarch_pkg.sv
src/issue_intf.sv
src/result_intf.sv
src/regfile.sv
src/issue_ctrl.sv
src/alu_unit.sv
src/mul_unit.sv
src/commit_unit.sv
src/blimp_core.sv
verif/blimp_core_tb.sv
